// ==== common/isa_pkg.sv ====
package isa_pkg;

    localparam logic [31:0] reset_pc = 32'h1c00_0000;

    // Major opcode in inst[31:26]
    localparam logic [5:0] major_alu   = 6'h00;
    localparam logic [5:0] major_lu12i = 6'h05;
    localparam logic [5:0] major_mem   = 6'h0a;
    localparam logic [5:0] op_jirl     = 6'h13;
    localparam logic [5:0] op_b        = 6'h14;
    localparam logic [5:0] op_bl       = 6'h15;
    localparam logic [5:0] op_beq      = 6'h16;
    localparam logic [5:0] op_bne      = 6'h17;

    // inst[31:15], register ops and immediate shifts
    localparam logic [16:0] op_add_w  = 17'h00020;
    localparam logic [16:0] op_sub_w  = 17'h00022;
    localparam logic [16:0] op_slt    = 17'h00024;
    localparam logic [16:0] op_sltu   = 17'h00025;
    localparam logic [16:0] op_nor    = 17'h00028;
    localparam logic [16:0] op_and    = 17'h00029;
    localparam logic [16:0] op_or     = 17'h0002a;
    localparam logic [16:0] op_xor    = 17'h0002b;
    localparam logic [16:0] op_slli_w = 17'h00081;
    localparam logic [16:0] op_srli_w = 17'h00089;
    localparam logic [16:0] op_srai_w = 17'h00091;

    // inst[31:22]
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_ld_w   = 10'h0a2;
    localparam logic [9:0] op_st_w   = 10'h0a6;

    // inst[31:25], bit 25 clear
    localparam logic [6:0] op_lu12i_w = 7'h0a;

    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] si12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri16_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] si20;
        logic [4:0]  rd;
    } fmt_1ri20_t;

    // offs26 is split, low half sits above the high half
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } fmt_i26_t;

    typedef union packed {
        fmt_3r_t    r3;
        fmt_2ri12_t ri12;
        fmt_2ri16_t ri16;
        fmt_1ri20_t ri20;
        fmt_i26_t   i26;
    } inst_u;

endpackage

// ==== common/core_pkg.sv ====
package core_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_always,
        br_reg
    } br_kind_e;

    typedef struct packed {
        alu_op_e     alu_op;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        src_reg_is_rd;
        logic        mem_read;
        logic        mem_write;
        logic        reg_write;
        logic [4:0]  dest;
        br_kind_e    branch;
        logic [31:0] imm;
        logic [31:0] br_offs;
    } ctrl_t;

    typedef enum logic [2:0] {
        st_if,
        st_id,
        st_exe,
        st_mem,
        st_wb
    } state_e;

    // One register write as seen at retirement
    typedef struct packed {
        logic [31:0] pc;
        logic        we;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } trace_t;

endpackage

// ==== core/decoder.sv ====
`timescale 1ns/1ps

module decoder
    import isa_pkg::*;
    import core_pkg::*;
(
    input  inst_u inst,
    output ctrl_t ctrl
);

    logic [31:0] ui5;
    logic [31:0] si12;
    logic [31:0] si20;
    logic [31:0] offs16;
    logic [31:0] offs26;

    assign ui5    = {27'b0, inst.r3.rk};
    assign si12   = {{20{inst.ri12.si12[11]}}, inst.ri12.si12};
    assign si20   = {inst.ri20.si20, 12'b0};
    assign offs16 = {{14{inst.ri16.offs16[15]}}, inst.ri16.offs16, 2'b0};
    assign offs26 = {{4{inst.i26.offs_hi[9]}}, inst.i26.offs_hi, inst.i26.offs_lo, 2'b0};

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = alu_add;
        ctrl.branch = br_none;
        ctrl.dest   = inst.r3.rd;
        case (inst.i26.opcode)
            major_alu: begin
                if (inst.ri12.opcode == op_addi_w) begin
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.imm         = si12;
                    ctrl.reg_write   = 1'b1;
                end else begin
                    ctrl.reg_write = 1'b1;
                    case (inst.r3.opcode)
                        op_add_w: ctrl.alu_op = alu_add;
                        op_sub_w: ctrl.alu_op = alu_sub;
                        op_slt:   ctrl.alu_op = alu_slt;
                        op_sltu:  ctrl.alu_op = alu_sltu;
                        op_nor:   ctrl.alu_op = alu_nor;
                        op_and:   ctrl.alu_op = alu_and;
                        op_or:    ctrl.alu_op = alu_or;
                        op_xor:   ctrl.alu_op = alu_xor;
                        op_slli_w, op_srli_w, op_srai_w: begin
                            ctrl.src2_is_imm = 1'b1;
                            ctrl.imm         = ui5;
                            if (inst.r3.opcode == op_slli_w)
                                ctrl.alu_op = alu_sll;
                            else if (inst.r3.opcode == op_srli_w)
                                ctrl.alu_op = alu_srl;
                            else
                                ctrl.alu_op = alu_sra;
                        end
                        default: ctrl.reg_write = 1'b0;
                    endcase
                end
            end
            major_mem: begin
                // Address is rj + si12 for both
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = si12;
                if (inst.ri12.opcode == op_ld_w) begin
                    ctrl.mem_read  = 1'b1;
                    ctrl.reg_write = 1'b1;
                end else if (inst.ri12.opcode == op_st_w) begin
                    ctrl.mem_write     = 1'b1;
                    ctrl.src_reg_is_rd = 1'b1;
                end
            end
            major_lu12i: begin
                if (inst.ri20.opcode == op_lu12i_w) begin
                    ctrl.alu_op      = alu_lui;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.imm         = si20;
                    ctrl.reg_write   = 1'b1;
                end
            end
            op_jirl, op_bl: begin
                // Link value pc + 4 comes out of the ALU
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = 32'd4;
                ctrl.reg_write   = 1'b1;
                if (inst.i26.opcode == op_bl) begin
                    ctrl.branch  = br_always;
                    ctrl.br_offs = offs26;
                    ctrl.dest    = 5'd1;
                end else begin
                    ctrl.branch  = br_reg;
                    ctrl.br_offs = offs16;
                end
            end
            op_b: begin
                ctrl.branch  = br_always;
                ctrl.br_offs = offs26;
            end
            op_beq, op_bne: begin
                ctrl.src_reg_is_rd = 1'b1;
                ctrl.br_offs       = offs16;
                ctrl.branch        = (inst.i26.opcode == op_beq) ? br_eq : br_ne;
            end
            default: ;
        endcase
        if (ctrl.dest == 5'd0)
            ctrl.reg_write = 1'b0;
    end

endmodule

// ==== core/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0)
            regs[waddr] <= wdata;
    end

    // r0 is wired to zero on the read side
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

// ==== core/alu.sv ====
`timescale 1ns/1ps

module alu
    import core_pkg::*;
(
    input  alu_op_e     op,
    input  logic [31:0] src1,
    input  logic [31:0] src2,
    output logic [31:0] result
);

    logic [4:0]  shamt;
    logic [31:0] diff;

    assign shamt = src2[4:0];
    assign diff  = src1 - src2;

    always_comb begin
        case (op)
            alu_add:  result = src1 + src2;
            alu_sub:  result = diff;
            alu_slt:  result = {31'b0, $signed(src1) < $signed(src2)};
            alu_sltu: result = {31'b0, src1 < src2};
            alu_and:  result = src1 & src2;
            alu_nor:  result = ~(src1 | src2);
            alu_or:   result = src1 | src2;
            alu_xor:  result = src1 ^ src2;
            alu_sll:  result = src1 << shamt;
            alu_srl:  result = src1 >> shamt;
            alu_sra:  result = $unsigned($signed(src1) >>> shamt);
            // Immediate is already shifted up by the decoder
            alu_lui:  result = src2;
            default:  result = 32'd0;
        endcase
    end

endmodule

// ==== core/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output trace_t      trace
);

    state_e      state;
    state_e      state_next;
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] next_pc_q;
    inst_u       inst_q;
    ctrl_t       ctrl;
    logic [4:0]  rf_raddr2;
    logic [31:0] rj_value;
    logic [31:0] rkd_value;
    logic [31:0] alu_src1;
    logic [31:0] alu_src2;
    logic [31:0] alu_result;
    logic [31:0] alu_q;
    logic        br_taken;
    logic [31:0] br_target;
    logic        rf_we;
    logic [31:0] wb_data;

    always_comb begin
        state_next = st_if;
        case (state)
            st_if: state_next = st_id;
            st_id: state_next = st_exe;
            st_exe: begin
                if (ctrl.mem_read || ctrl.mem_write)
                    state_next = st_mem;
                else if (ctrl.reg_write)
                    state_next = st_wb;
            end
            st_mem: begin
                if (ctrl.mem_read)
                    state_next = st_wb;
            end
            default: state_next = st_if;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= st_if;
            pc           <= reset_pc;
            data_sram_we <= 1'b0;
        end else begin
            state        <= state_next;
            data_sram_we <= (state == st_exe) && ctrl.mem_write;
            // PC moves only when the instruction retires
            if (state_next == st_if)
                pc <= (state == st_exe) ? next_pc : next_pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_id)
            inst_q <= inst_sram_rdata;
        if (state == st_exe) begin
            alu_q           <= alu_result;
            next_pc_q       <= next_pc;
            data_sram_wdata <= rkd_value;
        end
    end

    assign inst_sram_addr = pc;
    assign data_sram_addr = alu_q;

    decoder u_decoder (
        .inst (inst_q),
        .ctrl (ctrl)
    );

    assign rf_raddr2 = ctrl.src_reg_is_rd ? inst_q.r3.rd : inst_q.r3.rk;

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (inst_q.r3.rj),
        .rdata1 (rj_value),
        .raddr2 (rf_raddr2),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (ctrl.dest),
        .wdata  (wb_data)
    );

    assign alu_src1 = ctrl.src1_is_pc ? pc : rj_value;
    assign alu_src2 = ctrl.src2_is_imm ? ctrl.imm : rkd_value;

    alu u_alu (
        .op     (ctrl.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    // Branch resolution, valid during EXE
    always_comb begin
        case (ctrl.branch)
            br_eq:             br_taken = (rj_value == rkd_value);
            br_ne:             br_taken = (rj_value != rkd_value);
            br_always, br_reg: br_taken = 1'b1;
            default:           br_taken = 1'b0;
        endcase
    end

    assign br_target = (ctrl.branch == br_reg) ? rj_value + ctrl.br_offs
                                               : pc + ctrl.br_offs;
    assign next_pc   = br_taken ? br_target : pc + 32'd4;

    // Load data shows up from the SRAM in WB
    assign rf_we   = (state == st_wb) && ctrl.reg_write;
    assign wb_data = ctrl.mem_read ? data_sram_rdata : alu_q;

    assign trace.pc    = pc;
    assign trace.we    = rf_we;
    assign trace.wnum  = ctrl.dest;
    assign trace.wdata = wb_data;

endmodule

// ==== verification/tb_program.svh ====
// Instruction encoders on top of the shared union

function automatic logic [31:0] enc_3r(logic [16:0] op, logic [4:0] rk, logic [4:0] rj,
                                       logic [4:0] rd);
    inst_u w;
    w.r3 = fmt_3r_t'{op, rk, rj, rd};
    return w;
endfunction

function automatic logic [31:0] enc_ri12(logic [9:0] op, logic [11:0] si12, logic [4:0] rj,
                                         logic [4:0] rd);
    inst_u w;
    w.ri12 = fmt_2ri12_t'{op, si12, rj, rd};
    return w;
endfunction

function automatic logic [31:0] enc_ri16(logic [5:0] op, logic [15:0] offs, logic [4:0] rj,
                                         logic [4:0] rd);
    inst_u w;
    w.ri16 = fmt_2ri16_t'{op, offs, rj, rd};
    return w;
endfunction

function automatic logic [31:0] enc_lu12i(logic [19:0] si20, logic [4:0] rd);
    inst_u w;
    w.ri20 = fmt_1ri20_t'{op_lu12i_w, si20, rd};
    return w;
endfunction

function automatic logic [31:0] enc_i26(logic [5:0] op, logic [25:0] offs);
    inst_u w;
    w.i26 = fmt_i26_t'{op, offs[15:0], offs[25:16]};
    return w;
endfunction

task automatic emit(logic [31:0] word);
    prog[prog_len] = word;
    prog_len++;
endtask

// lu12i.w then addi.w, upper part rounded for the signed low half
task automatic load_const(logic [4:0] rd, logic [31:0] value);
    logic [31:0] hi;
    hi = value + 32'h800;
    emit(enc_lu12i(hi[31:12], rd));
    emit(enc_ri12(op_addi_w, value[11:0], rd, rd));
endtask

task automatic build_program(int test);
    logic [16:0] rr_ops [8];
    logic [31:0] r;
    rr_ops = '{op_add_w, op_sub_w, op_slt, op_sltu, op_nor, op_and, op_or, op_xor};
    prog_len = 0;
    case (test)
        1: begin
            for (int i = 0; i < 8; i++) begin
                load_const(5'd4, next_rand());
                load_const(5'd5, next_rand());
                emit(enc_3r(rr_ops[i], 5'd5, 5'd4, 5'(12 + i)));
            end
        end
        2: begin
            for (int i = 0; i < 3; i++) begin
                r = next_rand();
                load_const(5'd4, next_rand());
                emit(enc_3r(op_slli_w, r[4:0], 5'd4, 5'd6));
                emit(enc_3r(op_srli_w, r[9:5], 5'd4, 5'd7));
                emit(enc_3r(op_srai_w, r[14:10], 5'd4, 5'd8));
                emit(enc_ri12(op_addi_w, {1'b1, r[25:15]}, 5'd4, 5'd9));
                emit(enc_lu12i(r[31:12], 5'd10));
            end
        end
        3: begin
            load_const(5'd6, 32'h0000_0400);
            for (int i = 0; i < 4; i++) begin
                load_const(5'd4, next_rand());
                emit(enc_ri12(op_st_w, 12'(i * 12 - 16), 5'd6, 5'd4));
            end
            for (int i = 0; i < 4; i++)
                emit(enc_ri12(op_ld_w, 12'(i * 12 - 16), 5'd6, 5'(8 + i)));
            // Word never stored, holds the fill pattern
            emit(enc_ri12(op_ld_w, 12'h7fc, 5'd0, 5'd12));
        end
        4: begin
            load_const(5'd4, next_rand());
            emit(enc_ri12(op_addi_w, 12'd0, 5'd4, 5'd5));
            load_const(5'd6, next_rand());
            emit(enc_ri16(op_beq, 16'd2, 5'd4, 5'd5));
            emit(enc_ri12(op_addi_w, 12'd1, 5'd0, 5'd10));
            emit(enc_ri16(op_beq, 16'd2, 5'd4, 5'd6));
            emit(enc_ri12(op_addi_w, 12'd2, 5'd0, 5'd11));
            emit(enc_ri16(op_bne, 16'd2, 5'd4, 5'd6));
            emit(enc_ri12(op_addi_w, 12'd3, 5'd0, 5'd12));
            emit(enc_ri16(op_bne, 16'd2, 5'd4, 5'd5));
            emit(enc_ri12(op_addi_w, 12'd4, 5'd0, 5'd13));
            // Forward over two, back by two, then forward past the backward b
            emit(enc_i26(op_b, 26'd3));
            emit(enc_ri12(op_addi_w, 12'd5, 5'd0, 5'd14));
            emit(enc_i26(op_b, 26'd2));
            emit(enc_i26(op_b, 26'h3ff_fffe));
        end
        5: begin
            emit(enc_i26(op_bl, 26'd3));
            emit(enc_ri12(op_addi_w, 12'd7, 5'd0, 5'd20));
            emit(enc_i26(op_b, 26'd3));
            emit(enc_ri12(op_addi_w, 12'd9, 5'd0, 5'd21));
            emit(enc_ri16(op_jirl, 16'd0, 5'd1, 5'd0));
            emit(enc_ri16(op_jirl, 16'd6, 5'd1, 5'd3));
            emit(enc_ri12(op_addi_w, 12'd11, 5'd0, 5'd22));
            emit(enc_3r(op_add_w, 5'd1, 5'd3, 5'd23));
        end
        6: begin
            load_const(5'd4, next_rand());
            load_const(5'd5, next_rand());
            emit(enc_ri12(op_addi_w, 12'd123, 5'd0, 5'd0));
            emit(enc_lu12i(20'habcde, 5'd0));
            emit(enc_3r(op_add_w, 5'd5, 5'd4, 5'd0));
            emit(enc_ri12(op_ld_w, 12'h400, 5'd0, 5'd0));
            emit(enc_3r(op_add_w, 5'd4, 5'd0, 5'd9));
            emit(enc_3r(op_sub_w, 5'd0, 5'd4, 5'd10));
            emit(enc_3r(op_or, 5'd0, 5'd0, 5'd11));
        end
        default: ;
    endcase
    // Final self-loop
    emit(enc_i26(op_b, 26'd0));
    halt_pc = reset_pc + 32'(4 * (prog_len - 1));
endtask

// Reference model, one instruction on the shadow state
function void iss_step();
    inst_u       w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] d;
    logic [31:0] res;
    logic [31:0] next;
    logic [31:0] si12;
    logic [31:0] offs16;
    logic [31:0] offs26;
    logic [4:0]  dst;
    logic        wr;
    w      = prog[iss_pc[11:2]];
    a      = sh_reg[w.r3.rj];
    b      = sh_reg[w.r3.rk];
    d      = sh_reg[w.r3.rd];
    si12   = {{20{w.ri12.si12[11]}}, w.ri12.si12};
    offs16 = {{14{w.ri16.offs16[15]}}, w.ri16.offs16, 2'b00};
    offs26 = {{4{w.i26.offs_hi[9]}}, w.i26.offs_hi, w.i26.offs_lo, 2'b00};
    res    = '0;
    next   = iss_pc + 32'd4;
    dst    = w.r3.rd;
    wr     = 1'b1;
    case (w.i26.opcode)
        major_alu: begin
            if (w.ri12.opcode == op_addi_w) begin
                res = a + si12;
            end else begin
                case (w.r3.opcode)
                    op_add_w:  res = a + b;
                    op_sub_w:  res = a - b;
                    op_slt:    res = {31'b0, $signed(a) < $signed(b)};
                    op_sltu:   res = {31'b0, a < b};
                    op_nor:    res = ~(a | b);
                    op_and:    res = a & b;
                    op_or:     res = a | b;
                    op_xor:    res = a ^ b;
                    op_slli_w: res = a << w.r3.rk;
                    op_srli_w: res = a >> w.r3.rk;
                    op_srai_w: res = $signed(a) >>> w.r3.rk;
                    default:   wr = 1'b0;
                endcase
            end
        end
        major_mem: begin
            res = a + si12;
            if (w.ri12.opcode == op_ld_w) begin
                res = sh_mem[res[11:2]];
            end else begin
                wr = 1'b0;
                if (w.ri12.opcode == op_st_w)
                    sh_mem[res[11:2]] = d;
            end
        end
        major_lu12i: begin
            wr  = (w.ri20.opcode == op_lu12i_w);
            res = {w.ri20.si20, 12'b0};
        end
        op_jirl: begin
            res  = iss_pc + 32'd4;
            next = a + offs16;
        end
        op_bl: begin
            res  = iss_pc + 32'd4;
            dst  = 5'd1;
            next = iss_pc + offs26;
        end
        op_b: begin
            wr   = 1'b0;
            next = iss_pc + offs26;
        end
        op_beq, op_bne: begin
            wr = 1'b0;
            if ((a == d) == (w.i26.opcode == op_beq))
                next = iss_pc + offs16;
        end
        default: wr = 1'b0;
    endcase
    if (wr && dst != 5'd0) begin
        sh_reg[dst] = res;
        exp_q.push_back(trace_t'{iss_pc, 1'b1, dst, res});
    end
    iss_pc = next;
endfunction

// ==== verification/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu
    import isa_pkg::*;
    import core_pkg::*;
();

    localparam int num_tests = 6;

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata = '0;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata = '0;
    trace_t      dut_trace;

    logic [31:0] imem [1024];
    logic [31:0] dmem [1024];
    logic [31:0] prog [1024];
    logic [31:0] sh_mem [1024];
    logic [31:0] sh_reg [32];
    logic [31:0] iss_pc;
    logic [31:0] halt_pc;
    logic [31:0] rng_state = 32'h37d4_18b3;
    trace_t      exp_q [$];
    int          prog_len;
    int          trace_errors = 0;
    int          end_errors = 0;
    int          cycle_count = 0;
    int          cycle_limit = 400;
    string       test_names [num_tests] = '{"reg_ops", "imm_ops", "load_store",
                                            "branches", "link_jumps", "r0_writes"};

    function logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    `include "tb_program.svh"

    cpu_top DUT (
        .clk             (clk),
        .reset           (reset),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .data_sram_rdata (data_sram_rdata),
        .trace           (dut_trace)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // SRAM models with one cycle of read latency
    always @(posedge clk) begin
        inst_sram_rdata <= imem[inst_sram_addr[11:2]];
    end

    always @(posedge clk) begin
        if (data_sram_we)
            dmem[data_sram_addr[11:2]] <= data_sram_wdata;
        data_sram_rdata <= dmem[data_sram_addr[11:2]];
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout, program end not reached after %0d cycles", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    // Trace compare at mid-cycle
    always @(negedge clk) begin
        trace_t want;
        if (!reset && dut_trace.we) begin
            if (exp_q.size() == 0) begin
                $display("unexpected write to r%0d at pc %h", dut_trace.wnum, dut_trace.pc);
                trace_errors++;
            end else begin
                want = exp_q.pop_front();
                if (dut_trace.pc != want.pc) begin
                    $display("CHECK FAILED trace.pc got %h expected %h", dut_trace.pc, want.pc);
                    trace_errors++;
                end
                if (dut_trace.wnum != want.wnum) begin
                    $display("CHECK FAILED trace.wnum got %h expected %h at pc %h",
                             dut_trace.wnum, want.wnum, want.pc);
                    trace_errors++;
                end
                if (dut_trace.wdata != want.wdata) begin
                    $display("CHECK FAILED trace.wdata got %h expected %h at pc %h",
                             dut_trace.wdata, want.wdata, want.pc);
                    trace_errors++;
                end
            end
        end
    end

    initial begin
        int executed;
        int errors_before;
        int passed;
        passed = 0;
        reset <= 1'b1;
        for (int i = 0; i < 1024; i++) begin
            sh_mem[i] = 32'h6b1d_0000 ^ (32'(i) * 32'h0001_0083);
            dmem[i]   <= sh_mem[i];
        end
        for (int i = 0; i < 32; i++)
            sh_reg[i] = '0;
        for (int t = 1; t <= num_tests; t++) begin
            errors_before = trace_errors + end_errors;
            build_program(t);
            exp_q.delete();
            iss_pc   = reset_pc;
            executed = 0;
            while (iss_pc != halt_pc && executed < 1000) begin
                iss_step();
                executed++;
            end
            if (iss_pc != halt_pc) begin
                $display("reference model never reached the end of test %0d", t);
                end_errors++;
            end
            @(posedge clk);
            reset <= 1'b1;
            for (int i = 0; i < 1024; i++)
                imem[i] = (i < prog_len) ? prog[i] : 32'd0;
            repeat (4) @(posedge clk);
            reset <= 1'b0;
            cycle_limit = cycle_count + 5 * executed + 200;
            @(negedge clk);
            while (inst_sram_addr != halt_pc) begin
                @(negedge clk);
            end
            repeat (2) @(negedge clk);
            if (exp_q.size() != 0) begin
                $display("write expected but none seen, %0d left", exp_q.size());
                end_errors++;
            end
            for (int i = 0; i < 1024; i++) begin
                if (dmem[i] != sh_mem[i]) begin
                    $display("CHECK FAILED dmem[%0d] got %h expected %h", i, dmem[i], sh_mem[i]);
                    end_errors++;
                end
            end
            if (trace_errors + end_errors == errors_before) begin
                passed++;
                $display("test %0d %s ok, %0d instructions", t, test_names[t - 1], executed);
            end else begin
                $display("test %0d %s had errors", t, test_names[t - 1]);
            end
        end
        $display("%0d tests, %0d ok, %0d with errors, %0d check errors", num_tests, passed,
                 num_tests - passed, trace_errors + end_errors);
        if (trace_errors + end_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+verification
common/isa_pkg.sv
common/core_pkg.sv
core/decoder.sv
core/regfile.sv
core/alu.sv
core/cpu_top.sv
verification/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
